// File: Makefile
# Verilator build for the fractional sample-rate converter TX testbench

VERILATOR ?= verilator
TOP       := fsrc_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(OBJ_DIR)
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+hdl
hdl/fsrc_pkg.sv
hdl/fsrc_lane_en_gen.sv
hdl/fsrc_in_buffer.sv
hdl/fsrc_hole_insert.sv
hdl/fsrc_tx_top.sv
verif/fsrc_tb.sv

// File: hdl/fsrc_consts.svh
/*
 * Fractional sample-rate converter, TX side
 * Widths, lane count and the invalid-sample marker
 */

`ifndef FSRC_CONSTS_SVH
`define FSRC_CONSTS_SVH

`define FSRC_SAMPLE_W   16   // One sample
`define FSRC_NUM_LANES  4    // Samples per beat
`define FSRC_PHASE_W    16   // Accumulator width

// Most negative sample value, dropped later by the DAC path
`define FSRC_INVALID_SAMPLE {1'b1, {(`FSRC_SAMPLE_W-1){1'b0}}}

`endif

// File: hdl/fsrc_hole_insert.sv
/*
 * Hole inserter
 * Run control, residue store of up to two beats of samples, and
 * assembly of output beats from real samples and invalid markers
 */

`timescale 1ns/1ns
`default_nettype none

`include "fsrc_consts.svh"

module fsrc_hole_insert (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 start,
  input  logic                 stop,
  input  logic                 buf_valid,
  input  fsrc_pkg::beat_t      buf_beat,
  output logic                 buf_ready,
  input  fsrc_pkg::lane_mask_t lane_en,
  output logic                 lane_advance,
  output logic                 out_valid,
  output fsrc_pkg::beat_t      out_beat,
  input  logic                 out_ready
);

  import fsrc_pkg::*;

  localparam int RES_DEPTH = 2 * `FSRC_NUM_LANES;
  localparam int CNT_W     = $clog2(RES_DEPTH + 1);
  localparam int IDX_W     = $clog2(RES_DEPTH);

  run_state_t       state;
  logic             start_pend;   // Start seen, waiting for a beat
  logic             start_go;
  logic             byp;
  logic             conv_run;
  logic             out_free;
  logic             byp_take;
  logic             conv_take;
  logic             build;
  sample_t          res [RES_DEPTH];
  sample_t          res_nxt [RES_DEPTH];
  logic [CNT_W-1:0] res_cnt;
  logic [CNT_W-1:0] cnt_nxt;
  logic [CNT_W-1:0] used;         // Set bits of lane_en
  logic [IDX_W-1:0] wr_idx;
  beat_t            built;

  // ####################
  // Run control

  assign start_go = enable && !stop && (state != CONVERT) && (start || start_pend) && buf_valid;
  assign byp      = (state == BYPASS) && !enable;
  assign conv_run = (state == CONVERT) && enable && !stop;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      start_pend <= 1'b0;
    end else begin
      if (!enable)                state <= BYPASS;
      else if (stop)              state <= IDLE;
      else if (start_go)          state <= CONVERT;
      else if (state == BYPASS)   state <= IDLE;   // Enable rose, wait for start

      if (!enable || stop || start_go)      start_pend <= 1'b0;
      else if (start && state != CONVERT)   start_pend <= 1'b1;
    end
  end

  // ####################
  // Beat assembly

  assign out_free     = !out_valid || out_ready;
  assign build        = conv_run && out_free && (res_cnt >= used);
  assign conv_take    = conv_run && buf_valid && (res_cnt <= CNT_W'(`FSRC_NUM_LANES));
  assign byp_take     = byp && buf_valid && out_free;
  assign buf_ready    = byp ? out_free : (conv_run && (res_cnt <= CNT_W'(`FSRC_NUM_LANES)));
  assign lane_advance = build;

  // Enabled lanes take the oldest samples, lowest lane first
  always_comb begin
    used = '0;
    for (int i = 0; i < `FSRC_NUM_LANES; i++) begin
      if (lane_en[i]) begin
        built.lane[i] = res[IDX_W'(used)];
        used          = used + 1'b1;
      end else begin
        built.lane[i] = `FSRC_INVALID_SAMPLE;
      end
    end
  end

  // Residue update, consume first and then append
  always_comb begin
    res_nxt = res;
    cnt_nxt = res_cnt;
    if (build) begin
      for (int j = 0; j < RES_DEPTH; j++) begin
        if (j + int'(used) < RES_DEPTH) res_nxt[j] = res[IDX_W'(j + int'(used))];
      end
      cnt_nxt = res_cnt - used;
    end
    if (conv_take) begin
      for (int i = 0; i < `FSRC_NUM_LANES; i++) begin
        wr_idx          = IDX_W'(cnt_nxt) + IDX_W'(i);
        res_nxt[wr_idx] = buf_beat.lane[i];
      end
      cnt_nxt = cnt_nxt + CNT_W'(`FSRC_NUM_LANES);
    end else begin
      wr_idx = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      res_cnt <= conv_run ? cnt_nxt : '0;  // Dropped outside a run
      if (build || byp_take) out_valid <= 1'b1;
      else if (out_ready)    out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_nxt;
    if (byp_take)   out_beat <= buf_beat;
    else if (build) out_beat <= built;
  end

  // Downstream sees a held beat until it takes it
  a_out_stable : assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else $error("out_beat changed while stalled");

endmodule

`default_nettype wire

// File: hdl/fsrc_in_buffer.sv
/*
 * Input buffer
 * Two-entry FIFO with a registered in_ready
 */

`timescale 1ns/1ns
`default_nettype none

module fsrc_in_buffer (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  input  fsrc_pkg::beat_t in_beat,
  output logic            in_ready,
  output logic            buf_valid,
  output fsrc_pkg::beat_t buf_beat,
  input  logic            buf_ready
);

  import fsrc_pkg::*;

  beat_t      mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] fill;
  logic [1:0] fill_nxt;
  logic       push;
  logic       pop;

  assign push      = in_valid && in_ready;
  assign pop       = buf_valid && buf_ready;
  assign buf_valid = (fill != 2'd0);
  assign buf_beat  = mem[rd_ptr];

  always_comb begin
    fill_nxt = fill;
    if (push && !pop) fill_nxt = fill + 2'd1;
    if (pop && !push) fill_nxt = fill - 2'd1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      fill     <= 2'd0;
      in_ready <= 1'b0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      fill     <= fill_nxt;
      in_ready <= (fill_nxt != 2'd2);  // Drops after the filling beat
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_beat;
  end

  // Registered ready must have dropped by the time both entries are taken
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (reset)
    push |-> (fill != 2'd2)
  ) else $error("input buffer accepted a beat while full");

endmodule

`default_nettype wire

// File: hdl/fsrc_lane_en_gen.sv
/*
 * Lane-enable generator
 * One phase accumulator per lane. The carry out of the next
 * addition marks a lane that takes a real sample.
 */

`timescale 1ns/1ns
`default_nettype none

`include "fsrc_consts.svh"

module fsrc_lane_en_gen (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 phase_load,
  input  fsrc_pkg::phase_set_t phase_init,
  input  fsrc_pkg::phase_t     phase_step,
  input  logic                 lane_advance,
  output fsrc_pkg::lane_mask_t lane_en
);

  import fsrc_pkg::*;

  phase_t               acc [`FSRC_NUM_LANES];
  logic [`FSRC_PHASE_W:0] sum [`FSRC_NUM_LANES];  // Extra bit holds the carry

  genvar i;

  for (i = 0; i < `FSRC_NUM_LANES; i++) begin : g_lane

    // Mask for the beat about to be built
    always_comb begin
      sum[i]     = {1'b0, acc[i]} + {1'b0, phase_step};
      lane_en[i] = sum[i][`FSRC_PHASE_W];
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        acc[i] <= '0;
      end else if (phase_load) begin  // Load wins over advance
        acc[i] <= phase_init.ph[i];
      end else if (lane_advance) begin
        acc[i] <= sum[i][`FSRC_PHASE_W-1:0];  // Wraps modulo 2^W
      end
    end

  end

  // ####################
  // Checks

  // A zero step with a load racing an advance points at a
  // misconfigured converter on the control side
  a_no_load_advance_zero_step : assert property (
    @(posedge clk) disable iff (reset)
    !(phase_load && lane_advance && (phase_step == '0))
  ) else $error("phase_load and lane_advance together with zero phase_step");

endmodule

`default_nettype wire

// File: hdl/fsrc_pkg.sv
/*
 * Fractional sample-rate converter, TX side
 * Shared types for samples, beats, phases and run control
 */

`default_nettype none

`include "fsrc_consts.svh"

package fsrc_pkg;

  typedef logic [`FSRC_SAMPLE_W-1:0]  sample_t;
  typedef logic [`FSRC_PHASE_W-1:0]   phase_t;
  typedef logic [`FSRC_NUM_LANES-1:0] lane_mask_t;

  // Lane 0 sits in the LSBs and is the earliest sample
  typedef struct packed {
    sample_t [`FSRC_NUM_LANES-1:0] lane;
  } beat_t;

  typedef struct packed {
    phase_t [`FSRC_NUM_LANES-1:0] ph;  // Load values, one per lane
  } phase_set_t;

  typedef enum logic [1:0] {
    IDLE,
    BYPASS,
    CONVERT
  } run_state_t;

endpackage

`default_nettype wire

// File: hdl/fsrc_tx_top.sv
/*
 * Fractional sample-rate converter, TX side
 * Input buffer and lane-enable generator feeding the hole inserter
 */

`timescale 1ns/1ns
`default_nettype none

module fsrc_tx_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 start,
  input  logic                 stop,
  input  logic                 phase_load,
  input  fsrc_pkg::phase_set_t phase_init,
  input  fsrc_pkg::phase_t     phase_step,
  input  logic                 in_valid,
  input  fsrc_pkg::beat_t      in_beat,
  output logic                 in_ready,
  output logic                 out_valid,
  output fsrc_pkg::beat_t      out_beat,
  input  logic                 out_ready
);

  import fsrc_pkg::*;

  logic       buf_valid;
  logic       buf_ready;
  beat_t      buf_beat;
  lane_mask_t lane_en;
  logic       lane_advance;

  fsrc_in_buffer u_in_buffer (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .buf_valid (buf_valid),
    .buf_beat  (buf_beat),
    .buf_ready (buf_ready)
  );

  fsrc_lane_en_gen u_lane_en_gen (
    .clk          (clk),
    .reset        (reset),
    .phase_load   (phase_load),
    .phase_init   (phase_init),
    .phase_step   (phase_step),
    .lane_advance (lane_advance),
    .lane_en      (lane_en)
  );

  fsrc_hole_insert u_hole_insert (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .start        (start),
    .stop         (stop),
    .buf_valid    (buf_valid),
    .buf_beat     (buf_beat),
    .buf_ready    (buf_ready),
    .lane_en      (lane_en),
    .lane_advance (lane_advance),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .out_ready    (out_ready)
  );

endmodule

`default_nettype wire

// File: verif/fsrc_tb.sv
/*
 * Testbench for the fractional sample-rate converter, TX side
 * Table-driven bypass and convert runs, checked against a model
 * of the phase accumulators and the sample queue
 */

`timescale 1ns/1ns
`default_nettype none

`include "fsrc_consts.svh"

module fsrc_tb;

  import fsrc_pkg::*;

  localparam int         NL        = `FSRC_NUM_LANES;
  localparam int         NUM_TESTS = 8;
  localparam logic [1:0] M_BYPASS  = 2'd0;
  localparam logic [1:0] M_CONVERT = 2'd1;
  localparam logic [1:0] M_RELOAD  = 2'd2;  // New phases halfway through the run

  typedef struct packed {
    logic [1:0]  mode;
    logic        rand_phase;  // Random step and init
    logic [15:0] step;
    logic [7:0]  nbeats;
    logic        throttle;
  } test_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  logic       start;
  logic       stop;
  logic       phase_load;
  phase_set_t phase_init;
  phase_t     phase_step;
  logic       in_valid;
  beat_t      in_beat;
  logic       in_ready;
  logic       out_valid;
  beat_t      out_beat;
  logic       out_ready;

  test_t       tests [NUM_TESTS];
  beat_t       beats [64];
  sample_t     sq [$];     // Model sample queue
  beat_t       exp_q [$];
  phase_t      macc [NL];  // Model accumulators
  logic [31:0] lfsr = 32'd78193;
  logic        running;
  int          cur_test;
  int          test_errs;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  fsrc_tx_top uut (.*);

  always #2 clk = ~clk;

  // ####################
  // Random numbers and model

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Queue the beats, then build every output beat the samples can cover
  task automatic predict(input int first, input int count, input logic convert);
    logic [`FSRC_PHASE_W:0] s;
    lane_mask_t             mask;
    beat_t                  b;
    int                     need;
    for (int i = first; i < first + count; i++) begin
      if (!convert) begin
        exp_q.push_back(beats[i]);
      end else begin
        for (int l = 0; l < NL; l++) sq.push_back(beats[i].lane[l]);
      end
    end
    while (convert) begin
      need = 0;
      for (int l = 0; l < NL; l++) begin
        s       = {1'b0, macc[l]} + {1'b0, phase_step};
        mask[l] = s[`FSRC_PHASE_W];  // Carry marks a real sample
        need    = need + int'(mask[l]);
      end
      if (need > sq.size()) break;
      for (int l = 0; l < NL; l++) begin
        macc[l]   = macc[l] + phase_step;
        b.lane[l] = mask[l] ? sq.pop_front() : `FSRC_INVALID_SAMPLE;
      end
      exp_q.push_back(b);
    end
  endtask

  // ####################
  // Drivers and monitors

  task automatic load_phases();
    @(negedge clk);
    phase_load = 1'b1;
    for (int l = 0; l < NL; l++) macc[l] = phase_init.ph[l];
    @(negedge clk);
    phase_load = 1'b0;
  endtask

  task automatic send(input int first, input int count, input logic with_start);
    for (int i = first; i < first + count; i++) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_beat  = beats[i];
      start    = with_start && (i == first);  // Strobe with the first beat
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
    start    = 1'b0;
  endtask

  task automatic collect(input int want);
    beat_t e;
    int    n;
    n = 0;
    while (n < want) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        e = exp_q.pop_front();
        for (int l = 0; l < NL; l++) begin
          if (out_beat.lane[l] !== e.lane[l]) begin
            $display("CHECK FAILED at %0t ns: test %0d beat %0d lane %0d expected %h got %h",
                     $time, cur_test, n, l, e.lane[l], out_beat.lane[l]);
            test_errs++;
          end
        end
        n++;
      end
    end
    running = 1'b0;
  endtask

  task automatic pace_out(input logic throttle);
    logic [31:0] r;
    while (running) begin
      @(negedge clk);
      if (throttle) begin
        draw_bits(1, r);
        out_ready = r[0];
      end else begin
        out_ready = 1'b1;
      end
    end
    out_ready = 1'b1;
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      if (out_valid) begin
        $display("test %0d: an output beat appeared at %0t ns where none was due",
                 cur_test, $time);
        test_errs++;
      end
    end
  endtask

  task automatic run_segment(input int first, input int count, input logic convert,
                             input logic with_start, input logic throttle);
    int want;
    predict(first, count, convert);
    want    = exp_q.size();
    running = 1'b1;
    fork
      send(first, count, with_start);
      collect(want);
      pace_out(throttle);
    join
    check_quiet(6);
  endtask

  // ####################
  // Main sequence

  initial begin : watchdog
    int limit;
    limit = 1000;
    @(posedge clk);
    foreach (tests[i]) limit = limit + 40 * int'(tests[i].nbeats);
    repeat (limit) @(posedge clk);
    $display("Run timed out after %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    test_t       t;
    int          nb;
    tests[0] = '{M_BYPASS,  1'b0, 16'h0000, 8'd12, 1'b0};
    tests[1] = '{M_BYPASS,  1'b0, 16'h0000, 8'd12, 1'b1};
    tests[2] = '{M_CONVERT, 1'b0, 16'h8000, 8'd16, 1'b0};
    tests[3] = '{M_CONVERT, 1'b1, 16'h0000, 8'd20, 1'b0};
    tests[4] = '{M_CONVERT, 1'b1, 16'h0000, 8'd20, 1'b1};
    tests[5] = '{M_CONVERT, 1'b0, 16'h8000, 8'd16, 1'b1};  // Restart after a stop
    tests[6] = '{M_RELOAD,  1'b1, 16'h0000, 8'd20, 1'b0};
    tests[7] = '{M_BYPASS,  1'b0, 16'h0000, 8'd8,  1'b1};
    reset      = 1'b1;
    enable     = 1'b0;
    start      = 1'b0;
    stop       = 1'b0;
    phase_load = 1'b0;
    phase_init = '0;
    phase_step = '0;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_ready  = 1'b1;
    repeat (4) @(posedge clk);
    if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
      $display("CHECK FAILED at %0t ns: in_ready or out_valid not low during reset", $time);
      fail_cnt++;
    end
    @(negedge clk);
    reset = 1'b0;

    for (int k = 0; k < NUM_TESTS; k++) begin
      t         = tests[k];
      cur_test  = k;
      test_errs = 0;
      sq.delete();
      for (int i = 0; i < int'(t.nbeats); i++) begin
        for (int l = 0; l < NL; l++) begin
          draw_bits(16, r);
          beats[i].lane[l] = r[15:0];
        end
      end
      @(negedge clk);
      enable = (t.mode != M_BYPASS);
      if (t.mode == M_BYPASS) begin
        run_segment(0, int'(t.nbeats), 1'b0, 1'b0, t.throttle);
      end else begin
        phase_step = t.step;
        phase_init = '0;
        if (t.rand_phase) begin
          draw_bits(14, r);
          phase_step = {2'b01, r[13:0]};  // At least one carry every 4 beats
          for (int l = 0; l < NL; l++) begin
            draw_bits(16, r);
            phase_init.ph[l] = r[15:0];
          end
        end
        load_phases();
        nb = (t.mode == M_RELOAD) ? int'(t.nbeats) / 2 : int'(t.nbeats);
        run_segment(0, nb, 1'b1, 1'b1, t.throttle);
        if (t.mode == M_RELOAD) begin
          for (int l = 0; l < NL; l++) begin
            draw_bits(16, r);
            phase_init.ph[l] = r[15:0];
          end
          load_phases();  // Converter is stalled here, residue kept
          run_segment(nb, int'(t.nbeats) - nb, 1'b1, 1'b0, t.throttle);
        end
        @(negedge clk);
        stop = 1'b1;
        @(negedge clk);
        stop = 1'b0;
        phase_init = '0;  // Empty lane mask
        load_phases();
        check_quiet(10);
      end
      if (test_errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("test %0d mode %0d: %0d beats in, %0d mismatches",
               k, t.mode, t.nbeats, test_errs);
    end

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
